/* common/checkerPkg.sv */
// frame layout and reply rules assume node id 1 on a MOPS-Hub CANopen link; busId is 8 bits
package checkerPkg;

  localparam int frameW = 76;

  typedef logic [frameW-1:0] frame_t;

  // field widths, top of frame down
  localparam int cobW = 12;
  localparam int cmdW = 8;
  localparam int indexW = 16;
  localparam int subW = 8;
  localparam int dataW = 32;
  localparam int busIdW = 8;

  // field positions, built up from bit 0
  localparam int dataLsb = 0;
  localparam int dataMsb = dataLsb + dataW - 1;
  localparam int subLsb = dataMsb + 1;
  localparam int subMsb = subLsb + subW - 1;
  localparam int indexLsb = subMsb + 1;
  localparam int indexMsb = indexLsb + indexW - 1;
  localparam int cmdLsb = indexMsb + 1;
  localparam int cmdMsb = cmdLsb + cmdW - 1;
  localparam int cobLsb = cmdMsb + 1;
  localparam int cobMsb = cobLsb + cobW - 1;

  // bus id rides in the top byte of the data word
  localparam int busIdMsb = dataMsb;
  localparam int busIdLsb = dataMsb - busIdW + 1;

  typedef enum logic [2:0] {
    classNone,
    classNodeGuard,
    classSdoUpload,
    classSignIn,
    classTrim,
    classEcho
  } ruleClass_t;

  // request side
  localparam logic [cobW-1:0] cobNodeGuard = 12'h701;
  localparam logic [cobW-1:0] cobSdoRequest = 12'h601;
  localparam logic [cmdW-1:0] cmdUploadRequest = 8'h40;

  // reply side
  localparam logic [cobW-1:0] cobSdoReply = 12'h581;
  localparam logic [cmdW-1:0] cmdUploadReply = 8'h43;
  // node guard state goes in the command byte
  localparam logic [cmdW-1:0] nodeStateOperational = 8'h05;

  // oscillator trim request; the reply swaps in the bus id byte
  localparam frame_t trimPattern = 76'h555_aaaa_aaaa_aaaa_aaaa;

  // sign-in reads
  localparam logic [indexW-1:0] signInFirstIndex = 16'h2002;
  localparam logic [indexW-1:0] signInLastIndex = 16'h2004;
  localparam logic [subW-1:0] signInSubIndex = 8'h00;

  typedef struct packed {
    logic [indexW-1:0] objIndex;
    logic [subW-1:0] subIndex;
    logic [dataW-1:0] replyData;
  } sdoEntry_t;

  localparam int sdoTableSize = 12;

  // known object dictionary entries and their upload data
  localparam sdoEntry_t sdoTableEntries [sdoTableSize] = '{
    '{16'h1000, 8'h00, 32'h0000_0191},
    '{16'h1001, 8'h00, 32'h0000_0000},
    '{16'h1005, 8'h00, 32'h0000_0080},
    '{16'h1014, 8'h00, 32'h0000_0081},
    '{16'h1018, 8'h00, 32'h0000_0001},
    '{16'h1800, 8'h00, 32'h0000_0006},
    '{16'h1800, 8'h01, 32'h0000_0181},
    '{16'h1800, 8'h02, 32'h0000_00fe},
    '{16'h1801, 8'h00, 32'h0000_0006},
    '{16'h1801, 8'h01, 32'h0000_0281},
    '{16'h1801, 8'h02, 32'h0000_00fe},
    '{16'h2001, 8'h00, 32'h0000_0000}
  };

  localparam int countW = 16;

  // echo replies may change this many low bits freely
  localparam int echoIgnoreBits = 8;

endpackage

/* verilog/fourPhaseRx.sv */
// req must be synchronous to clk and frame stable while req is high; one frame per handshake
`timescale 1ns/1ps

module fourPhaseRx
(
  input  logic               clk,
  input  logic               rst,
  input  logic               req,
  input  checkerPkg::frame_t frame,
  output logic               ack,
  output logic               latched,
  output checkerPkg::frame_t data
);

  logic accept;

  // new transfer only counts while ack is low
  assign accept = req && !ack;

  // ack is the state bit: low waits for req, high waits for req to drop
  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      ack <= 1'b0;
      latched <= 1'b0;
    end
    else
    begin
      latched <= accept;
      if (accept)
        ack <= 1'b1;
      else if (!req)
        ack <= 1'b0;
    end
  end

  // frame held until the next handshake
  always_ff @(posedge clk)
  begin
    if (accept)
      data <= frame;
  end

endmodule

/* verilog/requestDecoder.sv */
// busId must be stable across a request and its response; one expectation held at a time
`timescale 1ns/1ps

module requestDecoder
(
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            latched,
  input  checkerPkg::frame_t              request,
  input  logic [checkerPkg::busIdW-1:0]   busId,
  output checkerPkg::frame_t              expValue,
  output checkerPkg::frame_t              expMask,
  output checkerPkg::ruleClass_t          expClass
);

  localparam checkerPkg::frame_t echoMask =
    {{(checkerPkg::frameW - checkerPkg::echoIgnoreBits){1'b1}},
     {checkerPkg::echoIgnoreBits{1'b0}}};

  logic [checkerPkg::cobW-1:0] cob;
  logic [checkerPkg::cmdW-1:0] cmd;
  logic [checkerPkg::indexW-1:0] objIndex;
  logic [checkerPkg::subW-1:0] subIndex;
  logic [checkerPkg::busIdW-1:0] reqBusId;
  logic isUpload;
  logic isSignIn;
  logic tableHit;
  logic [checkerPkg::dataW-1:0] tableData;
  logic [checkerPkg::dataW-1:0] signInData;
  checkerPkg::frame_t sdoReply;
  checkerPkg::frame_t nextValue;
  checkerPkg::frame_t nextMask;
  checkerPkg::ruleClass_t nextClass;

  assign cob = request[checkerPkg::cobMsb:checkerPkg::cobLsb];
  assign cmd = request[checkerPkg::cmdMsb:checkerPkg::cmdLsb];
  assign objIndex = request[checkerPkg::indexMsb:checkerPkg::indexLsb];
  assign subIndex = request[checkerPkg::subMsb:checkerPkg::subLsb];
  assign reqBusId = request[checkerPkg::busIdMsb:checkerPkg::busIdLsb];

  assign isUpload = (cob == checkerPkg::cobSdoRequest) && (cmd == checkerPkg::cmdUploadRequest);

  assign isSignIn = isUpload
    && (objIndex >= checkerPkg::signInFirstIndex)
    && (objIndex <= checkerPkg::signInLastIndex)
    && (subIndex == checkerPkg::signInSubIndex)
    && (reqBusId == busId);

  // entries are unique, so at most one row hits
  always_comb
  begin
    tableHit = 1'b0;
    tableData = '0;
    for (int i = 0; i < checkerPkg::sdoTableSize; i++)
    begin
      if (objIndex == checkerPkg::sdoTableEntries[i].objIndex &&
          subIndex == checkerPkg::sdoTableEntries[i].subIndex)
      begin
        tableHit = 1'b1;
        tableData = checkerPkg::sdoTableEntries[i].replyData;
      end
    end
  end

  // low flag set for 0x2002 and 0x2003 only
  assign signInData = {busId, {(checkerPkg::dataW - checkerPkg::busIdW - 1){1'b0}},
                       objIndex != checkerPkg::signInLastIndex};

  // upload reply echoes index and subindex
  always_comb
  begin
    sdoReply = '0;
    sdoReply[checkerPkg::cobMsb:checkerPkg::cobLsb] = checkerPkg::cobSdoReply;
    sdoReply[checkerPkg::cmdMsb:checkerPkg::cmdLsb] = checkerPkg::cmdUploadReply;
    sdoReply[checkerPkg::indexMsb:checkerPkg::indexLsb] = objIndex;
    sdoReply[checkerPkg::subMsb:checkerPkg::subLsb] = subIndex;
    sdoReply[checkerPkg::dataMsb:checkerPkg::dataLsb] = isSignIn ? signInData : tableData;
  end

  // priority: trim, node guard, sign-in, table, echo
  always_comb
  begin
    nextClass = checkerPkg::classEcho;
    nextValue = request;
    nextMask = echoMask;
    if (request == checkerPkg::trimPattern)
    begin
      nextClass = checkerPkg::classTrim;
      nextValue[checkerPkg::busIdMsb:checkerPkg::busIdLsb] = busId;
      nextMask = '1;
    end
    else if (cob == checkerPkg::cobNodeGuard)
    begin
      nextClass = checkerPkg::classNodeGuard;
      nextValue = '0;
      nextValue[checkerPkg::cobMsb:checkerPkg::cobLsb] = checkerPkg::cobNodeGuard;
      nextValue[checkerPkg::cmdMsb:checkerPkg::cmdLsb] = checkerPkg::nodeStateOperational;
      nextMask = '0;
      nextMask[checkerPkg::cobMsb:checkerPkg::cobLsb] = '1;
      nextMask[checkerPkg::cmdMsb:checkerPkg::cmdLsb] = '1;
    end
    else if (isSignIn)
    begin
      nextClass = checkerPkg::classSignIn;
      nextValue = sdoReply;
      nextMask = '1;
    end
    else if (isUpload && tableHit)
    begin
      nextClass = checkerPkg::classSdoUpload;
      nextValue = sdoReply;
      nextMask = '1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst)
      expClass <= checkerPkg::classNone;
    else if (latched)
      expClass <= nextClass;
  end

  always_ff @(posedge clk)
  begin
    if (latched)
    begin
      expValue <= nextValue;
      expMask <= nextMask;
    end
  end

endmodule

/* verilog/responseMatcher.sv */
// expectation is frozen the clock after the response strobe; strobes at least 2 cycles apart
`timescale 1ns/1ps

module responseMatcher
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   latched,
  input  checkerPkg::frame_t     response,
  input  checkerPkg::frame_t     expValue,
  input  checkerPkg::frame_t     expMask,
  input  checkerPkg::ruleClass_t expClass,
  output logic                   matchValid,
  output logic                   matchGood,
  output checkerPkg::ruleClass_t matchClass
);

  logic pending;
  checkerPkg::frame_t diff;
  checkerPkg::ruleClass_t sampledClass;

  // stage one: capture masked difference, so a new request cannot disturb it
  always_ff @(posedge clk)
  begin
    if (latched)
    begin
      diff <= (response ^ expValue) & expMask;
      sampledClass <= expClass;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      pending <= 1'b0;
      matchValid <= 1'b0;
    end
    else
    begin
      pending <= latched;
      matchValid <= pending;
    end
  end

  // stage two: reduce the difference, orphans always fail
  always_ff @(posedge clk)
  begin
    if (pending)
    begin
      matchGood <= (sampledClass != checkerPkg::classNone) && (diff == '0);
      matchClass <= sampledClass;
    end
  end

endmodule

/* verilog/verdictCounter.sv */
// counters saturate at all ones and clear only on reset
`timescale 1ns/1ps

module verdictCounter
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          matchValid,
  input  logic                          matchGood,
  input  checkerPkg::ruleClass_t        matchClass,
  output logic                          verdictValid,
  output logic                          verdictGood,
  output checkerPkg::ruleClass_t        verdictClass,
  output logic [checkerPkg::countW-1:0] checkCount,
  output logic [checkerPkg::countW-1:0] failCount
);

  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      verdictValid <= 1'b0;
      checkCount <= '0;
      failCount <= '0;
    end
    else
    begin
      verdictValid <= matchValid;
      if (matchValid && checkCount != '1)
        checkCount <= checkCount + 1'b1;
      if (matchValid && !matchGood && failCount != '1)
        failCount <= failCount + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (matchValid)
    begin
      verdictGood <= matchGood;
      verdictClass <= matchClass;
    end
  end

endmodule

/* verilog/responseChecker.sv */
// verdictValid pulses 3 cycles after rspAck rises; requests need ack 2 cycles ahead of rspAck
`timescale 1ns/1ps

module responseChecker
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic [checkerPkg::busIdW-1:0] busId,
  input  logic                          reqReq,
  input  checkerPkg::frame_t            reqFrame,
  output logic                          reqAck,
  input  logic                          rspReq,
  input  checkerPkg::frame_t            rspFrame,
  output logic                          rspAck,
  output logic                          verdictValid,
  output logic                          verdictGood,
  output checkerPkg::ruleClass_t        verdictClass,
  output logic [checkerPkg::countW-1:0] checkCount,
  output logic [checkerPkg::countW-1:0] failCount
);

  logic reqLatched;
  checkerPkg::frame_t reqData;
  logic rspLatched;
  checkerPkg::frame_t rspData;
  checkerPkg::frame_t expValue;
  checkerPkg::frame_t expMask;
  checkerPkg::ruleClass_t expClass;
  logic matchValid;
  logic matchGood;
  checkerPkg::ruleClass_t matchClass;

  fourPhaseRx reqRx
  (
    .clk(clk),
    .rst(rst),
    .req(reqReq),
    .frame(reqFrame),
    .ack(reqAck),
    .latched(reqLatched),
    .data(reqData)
  );

  fourPhaseRx rspRx
  (
    .clk(clk),
    .rst(rst),
    .req(rspReq),
    .frame(rspFrame),
    .ack(rspAck),
    .latched(rspLatched),
    .data(rspData)
  );

  requestDecoder decoder
  (
    .clk(clk),
    .rst(rst),
    .latched(reqLatched),
    .request(reqData),
    .busId(busId),
    .expValue(expValue),
    .expMask(expMask),
    .expClass(expClass)
  );

  responseMatcher matcher
  (
    .clk(clk),
    .rst(rst),
    .latched(rspLatched),
    .response(rspData),
    .expValue(expValue),
    .expMask(expMask),
    .expClass(expClass),
    .matchValid(matchValid),
    .matchGood(matchGood),
    .matchClass(matchClass)
  );

  verdictCounter counter
  (
    .clk(clk),
    .rst(rst),
    .matchValid(matchValid),
    .matchGood(matchGood),
    .matchClass(matchClass),
    .verdictValid(verdictValid),
    .verdictGood(verdictGood),
    .verdictClass(verdictClass),
    .checkCount(checkCount),
    .failCount(failCount)
  );

endmodule

/* bench/responseChecker_props.sv */
// bound into responseChecker; rst must be low for at least one clock before traffic starts
`timescale 1ns/1ps

module checkerProps
(
  input logic clk,
  input logic rst,
  input logic reqReq,
  input logic reqAck,
  input logic rspReq,
  input logic rspAck,
  input logic verdictValid
);

  // ack rises only on a live req
  ackRiseOnReq: assert property (@(posedge clk) disable iff (!rst)
    (!$rose(reqAck) || $past(reqReq)) && (!$rose(rspAck) || $past(rspReq)))
    else $error("ack rose while its req was low");

  ackHoldWhileReq: assert property (@(posedge clk) disable iff (!rst)
    (!$fell(reqAck) || !$past(reqReq)) && (!$fell(rspAck) || !$past(rspReq)))
    else $error("ack fell while its req was still high");

  // decode, compare and count stages
  verdictLatency: assert property (@(posedge clk) disable iff (!rst)
    $rose(rspAck) |-> ##3 verdictValid)
    else $error("verdictValid missing three cycles after rspAck rose");

endmodule

bind responseChecker checkerProps props
(
  .clk(clk),
  .rst(rst),
  .reqReq(reqReq),
  .reqAck(reqAck),
  .rspReq(rspReq),
  .rspAck(rspAck),
  .verdictValid(verdictValid)
);

/* bench/responseChecker_tb.sv */
// busId is drawn once per run; every response is judged against the last request sent before it
`timescale 1ns/1ps

module responseChecker_tb;

  localparam int resetCycles = 8;
  // orphan 1, table 36, sign-in 12, node guard 3, trim 3, echo 12
  localparam int plannedTransfers = 67;
  localparam checkerPkg::frame_t trimFrame = 76'h555_aaaa_aaaa_aaaa_aaaa;

  // object dictionary rows as {index, subindex} and their upload data
  localparam logic [23:0] sdoKeys [12] = '{24'h1000_00, 24'h1001_00, 24'h1005_00,
    24'h1014_00, 24'h1018_00, 24'h1800_00, 24'h1800_01, 24'h1800_02, 24'h1801_00,
    24'h1801_01, 24'h1801_02, 24'h2001_00};
  localparam logic [31:0] sdoData [12] = '{32'h191, 32'h0, 32'h80, 32'h81, 32'h1,
    32'h6, 32'h181, 32'hfe, 32'h6, 32'h281, 32'hfe, 32'h0};

  logic clk;
  logic rst;
  logic [7:0] busId;
  logic reqReq;
  checkerPkg::frame_t reqFrame;
  logic reqAck;
  logic rspReq;
  checkerPkg::frame_t rspFrame;
  logic rspAck;
  logic verdictValid;
  logic verdictGood;
  checkerPkg::ruleClass_t verdictClass;
  logic [15:0] checkCount;
  logic [15:0] failCount;

  checkerPkg::frame_t storedReq;
  logic haveReq;
  // {good, class} per response still waiting for its verdict
  logic [3:0] expQ [$];
  logic [3:0] expVerdict;
  int checks = 0;
  int fails = 0;
  int rspCount = 0;
  int badCount = 0;
  checkerPkg::frame_t request;
  checkerPkg::frame_t reply;
  logic [15:0] idx;
  int bitPos;

  responseChecker responseChecker_i
  (
    .clk(clk),
    .rst(rst),
    .busId(busId),
    .reqReq(reqReq),
    .reqFrame(reqFrame),
    .reqAck(reqAck),
    .rspReq(rspReq),
    .rspFrame(rspFrame),
    .rspAck(rspAck),
    .verdictValid(verdictValid),
    .verdictGood(verdictGood),
    .verdictClass(verdictClass),
    .checkCount(checkCount),
    .failCount(failCount)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic compareValue(input string name, input logic [75:0] got,
                              input logic [75:0] want);
    if (got !== want)
    begin
      $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, want);
      $display("*** TEST FAILED ***");
      $fatal(1, "value check failed");
    end
  endtask

  function automatic checkerPkg::frame_t randomFrame();
    return {12'($urandom), $urandom, $urandom};
  endfunction

  // rules: trim, node guard, sign-in, table upload, echo; nothing stored means orphan
  function automatic logic [3:0] expectedVerdict(input logic valid,
    input checkerPkg::frame_t req, input checkerPkg::frame_t rsp, input logic [7:0] id);
    checkerPkg::frame_t want;
    checkerPkg::frame_t care;
    checkerPkg::ruleClass_t cls;
    logic [15:0] index;
    logic upload;
    index = req[55:40];
    upload = req[75:56] == 20'h601_40;
    want = req;
    care = '1;
    cls = checkerPkg::classEcho;
    if (!valid)
      return {1'b0, checkerPkg::classNone};
    if (req == trimFrame)
    begin
      cls = checkerPkg::classTrim;
      want[31:24] = id;
    end
    else if (req[75:64] == 12'h701)
    begin
      cls = checkerPkg::classNodeGuard;
      want = {12'h701, 8'h05, 56'h0};
      care = {20'hfffff, 56'h0};
    end
    else if (upload && index >= 16'h2002 && index <= 16'h2004 && req[39:32] == 8'h00
             && req[31:24] == id)
    begin
      cls = checkerPkg::classSignIn;
      want = {12'h581, 8'h43, req[55:32], id, 23'h0, index != 16'h2004};
    end
    else
    begin
      care[7:0] = 8'h00;
      for (int i = 0; i < 12; i++)
      begin
        if (upload && req[55:32] == sdoKeys[i])
        begin
          cls = checkerPkg::classSdoUpload;
          want = {12'h581, 8'h43, sdoKeys[i], sdoData[i]};
          care = '1;
        end
      end
    end
    return {((rsp ^ want) & care) == '0, cls};
  endfunction

  task automatic handshake(input logic isRsp, input checkerPkg::frame_t f);
    string ackName;
    ackName = "reqAck";
    if (isRsp)
    begin
      ackName = "rspAck";
      rspFrame <= f;
      rspReq <= 1'b1;
    end
    else
    begin
      reqFrame <= f;
      reqReq <= 1'b1;
    end
    // ack one clock after req is seen, low one clock after req drops
    repeat (2) @(posedge clk);
    compareValue(ackName, isRsp ? rspAck : reqAck, 1'b1);
    if (isRsp)
      rspReq <= 1'b0;
    else
      reqReq <= 1'b0;
    repeat (2) @(posedge clk);
    compareValue(ackName, isRsp ? rspAck : reqAck, 1'b0);
  endtask

  task automatic sendRequest(input checkerPkg::frame_t f);
    handshake(1'b0, f);
    storedReq = f;
    haveReq = 1'b1;
  endtask

  task automatic sendResponse(input checkerPkg::frame_t f);
    logic [3:0] v;
    v = expectedVerdict(haveReq, storedReq, f, busId);
    expQ.push_back(v);
    rspCount++;
    if (!v[3])
      badCount++;
    handshake(1'b1, f);
  endtask

  always @(posedge clk)
  begin
    if (rst && verdictValid)
    begin
      if (expQ.size() == 0)
      begin
        $display("a verdict arrived while no response was outstanding");
        $display("*** TEST FAILED ***");
        $fatal(1, "unexpected verdict");
      end
      else
      begin
        expVerdict = expQ.pop_front();
        checks++;
        if (!expVerdict[3])
          fails++;
        compareValue("verdictGood", verdictGood, expVerdict[3]);
        compareValue("verdictClass", verdictClass, expVerdict[2:0]);
        compareValue("checkCount", checkCount, checks);
        compareValue("failCount", failCount, fails);
      end
    end
  end

  initial
  begin
    repeat (resetCycles + 40 * plannedTransfers) @(posedge clk);
    $display("timeout: the checks did not finish within %0d cycles",
             resetCycles + 40 * plannedTransfers);
    $display("*** TEST FAILED ***");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    void'($urandom(32'h2314));
    busId = 8'($urandom);
    // trim reply must differ from the bare pattern
    if (busId == 8'haa)
      busId = 8'h5a;
    rst = 1'b0;
    reqReq = 1'b0;
    rspReq = 1'b0;
    reqFrame = '0;
    rspFrame = '0;
    haveReq = 1'b0;
    repeat (resetCycles) @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);
    compareValue("reqAck rspAck verdictValid", {reqAck, rspAck, verdictValid}, 3'b000);
    compareValue("checkCount", checkCount, 0);
    compareValue("failCount", failCount, 0);

    // orphan
    sendResponse(randomFrame());

    for (int i = 0; i < 12; i++)
    begin
      sendRequest({12'h601, 8'h40, sdoKeys[i], 32'h0});
      reply = {12'h581, 8'h43, sdoKeys[i], sdoData[i]};
      sendResponse(reply);
      bitPos = $urandom_range(75, 0);
      reply[bitPos] = ~reply[bitPos];
      sendResponse(reply);
    end

    for (int i = 0; i < 3; i++)
    begin
      idx = 16'h2002 + 16'(i);
      sendRequest({12'h601, 8'h40, idx, 8'h00, busId, 24'h0});
      reply = {12'h581, 8'h43, idx, 8'h00, busId, 23'h0, idx != 16'h2004};
      sendResponse(reply);
      reply[31:24] = busId ^ 8'($urandom_range(255, 1));
      sendResponse(reply);
      reply[31:24] = busId;
      reply[0] = ~reply[0];
      sendResponse(reply);
    end

    request = randomFrame();
    request[75:64] = 12'h701;
    sendRequest(request);
    reply = randomFrame();
    reply[75:56] = 20'h701_05;
    sendResponse(reply);
    reply[63:56] = 8'h05 ^ 8'($urandom_range(255, 1));
    sendResponse(reply);

    sendRequest(trimFrame);
    reply = trimFrame;
    reply[31:24] = busId;
    sendResponse(reply);
    sendResponse(trimFrame);

    for (int i = 0; i < 4; i++)
    begin
      request = randomFrame();
      request[75:72] = 4'h3;
      sendRequest(request);
      reply = request;
      reply[7:0] = 8'($urandom);
      sendResponse(reply);
      bitPos = $urandom_range(75, 8);
      reply[bitPos] = ~reply[bitPos];
      sendResponse(reply);
    end

    while (expQ.size() != 0)
      @(posedge clk);
    @(posedge clk);
    compareValue("checkCount", checkCount, rspCount);
    compareValue("failCount", failCount, badCount);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* src.f */
common/checkerPkg.sv
verilog/fourPhaseRx.sv
verilog/requestDecoder.sv
verilog/responseMatcher.sv
verilog/verdictCounter.sv
verilog/responseChecker.sv
bench/responseChecker_props.sv
bench/responseChecker_tb.sv

/* run.sh */
#!/bin/sh
# needs Verilator 5 with timing support; result is read from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f \
  --top-module responseChecker_tb -o simv \
  && ./obj_dir/simv > sim.log 2>&1
grep -qs "\*\*\* TEST PASSED \*\*\*" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
